// File: include/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// byte address width for a 1 KiB space
`define MEM_ADDR_WIDTH 10

// RAM size in bytes
`define MEM_DEPTH 1024

// bytes per instruction or data word
`define WORD_BYTES 4

`endif

// File: design/memTypesPkg.sv
package memTypesPkg;

    // controller sequencing states
    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stLoad,
        stStore,
        stDone
    } ctrlState_t;

    typedef enum logic {
        opLoad,
        opStore
    } memOp_t;

    // data access size
    typedef enum logic [1:0] {
        lenByte,
        lenHalf,
        lenWord
    } accessLen_t;

    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } busOwner_t;

endpackage

// File: design/memBusPkg.sv
`include "mem_config.svh"

package memBusPkg;
    import memTypesPkg::*;

    typedef struct packed {
        logic                       en;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic                      done;
        logic [`WORD_BYTES*8-1:0] inst;
    } fetchResp_t;

    typedef struct packed {
        logic                       en;
        memOp_t                     op;
        accessLen_t                 len;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`WORD_BYTES*8-1:0]   wdata;
    } dataReq_t;

    typedef struct packed {
        logic                      done;
        logic [`WORD_BYTES*8-1:0] rdata;
    } dataResp_t;

    // byte RAM port
    typedef struct packed {
        logic                       we;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 wdata;
    } ramPort_t;

    // access issued by the FSM with a single-cycle start strobe
    typedef struct packed {
        logic                       start;
        logic                       isStore;
        accessLen_t                 len;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`WORD_BYTES*8-1:0]   wdata;
    } accessCmd_t;

endpackage

// File: design/byteRam.sv
`include "mem_config.svh"

module byteRam (
    input  logic                clk,
    input  memBusPkg::ramPort_t i_port,
    output logic [7:0]          o_rdata
);
    logic [7:0] mem [`MEM_DEPTH];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (i_port.we) begin
            mem[i_port.addr] <= i_port.wdata;
        end
        o_rdata <= mem[i_port.addr];
    end

endmodule

// File: design/byteCounter.sv
module byteCounter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_hold,
    input  logic                    i_start,
    input  logic                    i_advance,
    input  memTypesPkg::accessLen_t i_len,
    input  logic                    i_isFetch,
    output logic [1:0]              o_count,
    output logic                    o_lastByte
);
    import memTypesPkg::*;

    logic [1:0] lastIdx;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_count <= 2'd0;
            lastIdx <= 2'd0;
        end else if (!i_hold) begin
            if (i_start) begin
                o_count <= 2'd0;
                // fetches always take a full word
                if (i_isFetch) begin
                    lastIdx <= 2'd3;
                end else begin
                    case (i_len)
                        lenByte: lastIdx <= 2'd0;
                        lenHalf: lastIdx <= 2'd1;
                        default: lastIdx <= 2'd3;
                    endcase
                end
            end else if (i_advance && !o_lastByte) begin
                o_count <= o_count + 2'd1;
            end
        end
    end

    assign o_lastByte = (o_count == lastIdx);

endmodule

// File: design/memPortDriver.sv
`include "mem_config.svh"

module memPortDriver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_hold,
    input  memBusPkg::accessCmd_t i_cmd,
    input  logic [1:0]            i_count,
    output memBusPkg::ramPort_t   o_ram
);
    import memTypesPkg::*;

    logic [`MEM_ADDR_WIDTH-1:0] baseAddr;
    logic [`MEM_ADDR_WIDTH-1:0] curAddr;
    logic [`MEM_ADDR_WIDTH-1:0] lastAddr;
    logic [`WORD_BYTES*8-1:0]   storeWord;
    accessLen_t                 storeLen;
    logic                       storeActive;
    logic                       storeLast;

    always_ff @(posedge clk) begin
        if (i_cmd.start && !i_hold) begin
            baseAddr  <= i_cmd.addr;
            storeWord <= i_cmd.wdata;
            storeLen  <= i_cmd.len;
        end
        // address of the byte now sitting in the RAM output register
        if (!i_hold) begin
            lastAddr <= curAddr;
        end
    end

    always_comb begin
        case (storeLen)
            lenByte: storeLast = (i_count == 2'd0);
            lenHalf: storeLast = (i_count == 2'd1);
            default: storeLast = (i_count == 2'd3);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            storeActive <= 1'b0;
        end else if (!i_hold) begin
            if (i_cmd.start) begin
                storeActive <= i_cmd.isStore;
            end else if (storeActive && storeLast) begin
                storeActive <= 1'b0;
            end
        end
    end

    assign curAddr = baseAddr + {{(`MEM_ADDR_WIDTH-2){1'b0}}, i_count};

    // under hold, re-read the pending byte so the read pipeline keeps it
    assign o_ram.addr  = i_hold ? lastAddr : curAddr;
    assign o_ram.wdata = storeWord[8*i_count +: 8];
    assign o_ram.we    = storeActive && !i_hold;

endmodule

// File: design/wordAssembler.sv
`include "mem_config.svh"

module wordAssembler (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_hold,
    input  memBusPkg::accessCmd_t    i_cmd,
    input  logic [1:0]               i_count,
    input  logic                     i_advance,
    input  logic [7:0]               i_ramData,
    output logic [`WORD_BYTES*8-1:0] o_word
);
    // byte index and valid delayed to match RAM latency
    logic [1:0] laneD;
    logic       validD;

    always_ff @(posedge clk) begin
        if (rst) begin
            validD <= 1'b0;
        end else if (!i_hold) begin
            validD <= i_advance;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            laneD <= i_count;
            // cleared lanes give the zero extension of short loads
            if (i_cmd.start) begin
                o_word <= '0;
            end else if (validD) begin
                o_word[8*laneD +: 8] <= i_ramData;
            end
        end
    end

endmodule

// File: design/memCtrlFsm.sv
module memCtrlFsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_hold,
    input  memBusPkg::fetchReq_t    i_fetchReq,
    input  memBusPkg::dataReq_t     i_dataReq,
    input  logic                    i_lastByte,
    input  logic [31:0]             i_fetchWord,
    output memBusPkg::accessCmd_t   o_cmd,
    output logic                    o_advance,
    output memBusPkg::fetchResp_t   o_fetchResp,
    output logic                    o_dataDone,
    output memTypesPkg::busOwner_t  o_busOwner,
    output memTypesPkg::ctrlState_t o_state
);
    import memTypesPkg::*;

    ctrlState_t state;
    busOwner_t  owner;
    logic       doneReg;
    logic       active;
    logic       accept;

    assign active = (state == stFetch) || (state == stLoad) || (state == stStore);
    assign accept = (state == stIdle) && !i_hold && (i_dataReq.en || i_fetchReq.en);

    // one byte per unheld cycle while an access is running
    assign o_advance = active && !i_hold;

    // data requester wins when both are asking
    always_comb begin
        o_cmd.start = accept;
        o_cmd.wdata = i_dataReq.wdata;
        if (i_dataReq.en) begin
            o_cmd.isStore = (i_dataReq.op == opStore);
            o_cmd.len     = i_dataReq.len;
            o_cmd.addr    = i_dataReq.addr;
        end else begin
            o_cmd.isStore = 1'b0;
            o_cmd.len     = lenWord;
            o_cmd.addr    = i_fetchReq.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= stIdle;
            owner   <= ownNone;
            doneReg <= 1'b0;
        end else if (!i_hold) begin
            case (state)
                stIdle: begin
                    if (i_dataReq.en) begin
                        owner <= ownData;
                        if (i_dataReq.op == opStore) begin
                            state <= stStore;
                        end else begin
                            state <= stLoad;
                        end
                    end else if (i_fetchReq.en) begin
                        owner <= ownFetch;
                        state <= stFetch;
                    end
                end
                stFetch, stLoad, stStore: begin
                    if (i_lastByte) begin
                        state <= stDone;
                    end
                end
                stDone: begin
                    // first cycle drains the RAM read, second carries done
                    if (doneReg) begin
                        doneReg <= 1'b0;
                        owner   <= ownNone;
                        state   <= stIdle;
                    end else begin
                        doneReg <= 1'b1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // done stays pending while held
    assign o_fetchResp.done = doneReg && (owner == ownFetch) && !i_hold;
    assign o_fetchResp.inst = i_fetchWord;
    assign o_dataDone       = doneReg && (owner == ownData) && !i_hold;

    assign o_busOwner = owner;
    assign o_state    = state;

endmodule

// File: design/memSubsystem.sv
`include "mem_config.svh"

module memSubsystem (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_hold,
    input  memBusPkg::fetchReq_t   i_fetchReq,
    input  memBusPkg::dataReq_t    i_dataReq,
    output memBusPkg::fetchResp_t  o_fetchResp,
    output memBusPkg::dataResp_t   o_dataResp,
    output memTypesPkg::busOwner_t o_busOwner
);
    import memBusPkg::*;

    accessCmd_t               cmd;
    ramPort_t                 ramPort;
    logic                     advance;
    logic                     lastByte;
    logic                     dataDone;
    logic [1:0]               count;
    logic [7:0]               ramData;
    logic [`WORD_BYTES*8-1:0] word;

    memCtrlFsm fsm (
        .clk         (clk),
        .rst         (rst),
        .i_hold      (i_hold),
        .i_fetchReq  (i_fetchReq),
        .i_dataReq   (i_dataReq),
        .i_lastByte  (lastByte),
        .i_fetchWord (word),
        .o_cmd       (cmd),
        .o_advance   (advance),
        .o_fetchResp (o_fetchResp),
        .o_dataDone  (dataDone),
        .o_busOwner  (o_busOwner),
        .o_state     ()
    );

    // a start without a data request is a fetch
    byteCounter counter (
        .clk        (clk),
        .rst        (rst),
        .i_hold     (i_hold),
        .i_start    (cmd.start),
        .i_advance  (advance),
        .i_len      (cmd.len),
        .i_isFetch  (!i_dataReq.en),
        .o_count    (count),
        .o_lastByte (lastByte)
    );

    memPortDriver driver (
        .clk     (clk),
        .rst     (rst),
        .i_hold  (i_hold),
        .i_cmd   (cmd),
        .i_count (count),
        .o_ram   (ramPort)
    );

    wordAssembler assembler (
        .clk       (clk),
        .rst       (rst),
        .i_hold    (i_hold),
        .i_cmd     (cmd),
        .i_count   (count),
        .i_advance (advance),
        .i_ramData (ramData),
        .o_word    (word)
    );

    byteRam ram (
        .clk     (clk),
        .i_port  (ramPort),
        .o_rdata (ramData)
    );

    assign o_dataResp.done  = dataDone;
    assign o_dataResp.rdata = word;

endmodule

// File: verification/memSubsystem_assert.sv
module memSubsystemAssert (
    input logic                    clk,
    input logic                    rst,
    input logic                    i_hold,
    input memBusPkg::accessCmd_t   i_cmd,
    input logic                    i_fetchDone,
    input logic                    i_dataDone,
    input memTypesPkg::busOwner_t  i_busOwner,
    input memTypesPkg::ctrlState_t i_state
);
    import memTypesPkg::*;

    logic       anyDone;
    logic       inFlight;
    logic [3:0] unheldEdges;
    logic [3:0] expectLat;

    assign anyDone = i_fetchDone || i_dataDone;

    // unheld edges counted with the accepting edge as the first
    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight    <= 1'b0;
            unheldEdges <= 4'd0;
            expectLat   <= 4'd0;
        end else if (!i_hold) begin
            if (i_cmd.start) begin
                inFlight    <= 1'b1;
                unheldEdges <= 4'd1;
                case (i_cmd.len)
                    lenByte: expectLat <= 4'd3;
                    lenHalf: expectLat <= 4'd4;
                    default: expectLat <= 4'd6;
                endcase
            end else begin
                if (unheldEdges != 4'd0 && unheldEdges != 4'd15) begin
                    unheldEdges <= unheldEdges + 4'd1;
                end
                if (anyDone) begin
                    inFlight <= 1'b0;
                end
            end
        end
    end

    donePulse: assert property (@(posedge clk) disable iff (rst) anyDone |=> !anyDone)
        else $error("done lasted more than one cycle");

    noDoneHeld: assert property (@(posedge clk) disable iff (rst) i_hold |-> !anyDone)
        else $error("done while hold is high");

    doneLatency: assert property (@(posedge clk) disable iff (rst)
        anyDone |-> (unheldEdges == expectLat))
        else $error("done arrived at the wrong unheld edge");

    doneDue: assert property (@(posedge clk) disable iff (rst)
        (inFlight && !i_hold && unheldEdges == expectLat) |-> anyDone)
        else $error("done missing at its expected edge");

    idleOwner: assert property (@(posedge clk) disable iff (rst)
        (i_state == stIdle) |-> (i_busOwner == ownNone))
        else $error("bus owner set while idle");

endmodule

bind memCtrlFsm memSubsystemAssert fsmChecks (
    .clk         (clk),
    .rst         (rst),
    .i_hold      (i_hold),
    .i_cmd       (o_cmd),
    .i_fetchDone (o_fetchResp.done),
    .i_dataDone  (o_dataDone),
    .i_busOwner  (o_busOwner),
    .i_state     (o_state)
);

// File: verification/memSubsystemTb.sv
`include "mem_config.svh"

module memSubsystemTb;
    import memTypesPkg::*;
    import memBusPkg::*;

    typedef logic [`MEM_ADDR_WIDTH-1:0] byteAddr_t;

    localparam int OpLimit     = 400;
    localparam int CyclesPerOp = 12;

    logic       clk;
    logic       rst;
    logic       hold;
    fetchReq_t  fetchReq;
    dataReq_t   dataReq;
    fetchResp_t fetchResp;
    dataResp_t  dataResp;
    busOwner_t  busOwner;

    // reference copy of the RAM
    logic [7:0] model [`MEM_DEPTH];
    byteAddr_t  storedWords [$];
    int         seed;
    int         cycles;
    logic       holdMode;

    memSubsystem dut (
        .clk         (clk),
        .rst         (rst),
        .i_hold      (hold),
        .i_fetchReq  (fetchReq),
        .i_dataReq   (dataReq),
        .o_fetchResp (fetchResp),
        .o_dataResp  (dataResp),
        .o_busOwner  (busOwner)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopWithFailure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkOwner(input string name, input busOwner_t expected,
                              input busOwner_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %s, actual %s", name, expected.name(), actual.name());
            stopWithFailure();
        end
    endtask

    function automatic int lenBytes(input accessLen_t len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian read with zeroed upper lanes
    function automatic logic [31:0] modelRead(input byteAddr_t addr, input int nBytes);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < nBytes; k++) begin
            word[8*k +: 8] = model[addr + `MEM_ADDR_WIDTH'(k)];
        end
        return word;
    endfunction

    function automatic byteAddr_t randAligned();
        logic [31:0] r;
        r = $random(seed);
        return {r[`MEM_ADDR_WIDTH-3:0], 2'b00};
    endfunction

    function automatic accessLen_t randShortLen();
        logic [31:0] r;
        r = $random(seed);
        return r[0] ? lenHalf : lenByte;
    endfunction

    // an address inside a word that is already written
    function automatic byteAddr_t pickAddr(input accessLen_t len);
        logic [31:0] r;
        byteAddr_t   base;
        r = $random(seed);
        base = storedWords[r % storedWords.size()];
        case (len)
            lenByte: return {base[`MEM_ADDR_WIDTH-1:2], r[5:4]};
            lenHalf: return {base[`MEM_ADDR_WIDTH-1:2], r[5], 1'b0};
            default: return base;
        endcase
    endfunction

    // drive point after each edge with a fresh hold level
    task automatic nextCycle();
        logic [31:0] r;
        @(posedge clk);
        #10;
        r = $random(seed);
        hold = holdMode && (r[1:0] == 2'b00);
    endtask

    task automatic runData(input memOp_t op, input accessLen_t len, input byteAddr_t addr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
        bit gotDone;
        dataReq.op    = op;
        dataReq.len   = len;
        dataReq.addr  = addr;
        dataReq.wdata = wdata;
        dataReq.en    = 1'b1;
        gotDone = 1'b0;
        while (!gotDone) begin
            @(negedge clk);
            if (dataResp.done) begin
                rdata = dataResp.rdata;
                gotDone = 1'b1;
            end
            nextCycle();
        end
        dataReq.en = 1'b0;
    endtask

    task automatic doStore(input accessLen_t len, input byteAddr_t addr, input logic [31:0] wdata);
        logic [31:0] unused;
        runData(opStore, len, addr, wdata, unused);
        for (int k = 0; k < lenBytes(len); k++) begin
            model[addr + `MEM_ADDR_WIDTH'(k)] = wdata[8*k +: 8];
        end
        if (len == lenWord) begin
            storedWords.push_back(addr);
        end
    endtask

    task automatic doLoad(input string name, input accessLen_t len, input byteAddr_t addr);
        logic [31:0] rdata;
        runData(opLoad, len, addr, '0, rdata);
        checkWord(name, modelRead(addr, lenBytes(len)), rdata);
    endtask

    task automatic doFetch(input string name, input byteAddr_t addr);
        bit gotDone;
        fetchReq.addr = addr;
        fetchReq.en   = 1'b1;
        gotDone = 1'b0;
        while (!gotDone) begin
            @(negedge clk);
            if (fetchResp.done) begin
                checkWord(name, modelRead(addr, 4), fetchResp.inst);
                gotDone = 1'b1;
            end
            nextCycle();
        end
        fetchReq.en = 1'b0;
    endtask

    // data must be served first when both requesters raise en together
    task automatic runDual(input string name, input byteAddr_t dataAddr, input byteAddr_t fetchAddr);
        busOwner_t owners [$];
        bit        dataSeen;
        bit        fetchSeen;
        dataReq.op    = opLoad;
        dataReq.len   = lenWord;
        dataReq.addr  = dataAddr;
        dataReq.en    = 1'b1;
        fetchReq.addr = fetchAddr;
        fetchReq.en   = 1'b1;
        dataSeen  = 1'b0;
        fetchSeen = 1'b0;
        while (!fetchSeen) begin
            @(negedge clk);
            if (busOwner != ownNone && (owners.size() == 0 || owners[$] != busOwner)) begin
                owners.push_back(busOwner);
            end
            if (dataResp.done) begin
                checkWord({name, " data"}, modelRead(dataAddr, 4), dataResp.rdata);
                dataSeen = 1'b1;
            end
            if (fetchResp.done) begin
                if (!dataSeen) begin
                    $display("%s: fetch done arrived before data done", name);
                    stopWithFailure();
                end
                checkWord({name, " inst"}, modelRead(fetchAddr, 4), fetchResp.inst);
                fetchSeen = 1'b1;
            end
            nextCycle();
            if (dataSeen) begin
                dataReq.en = 1'b0;
            end
        end
        fetchReq.en = 1'b0;
        if (owners.size() != 2) begin
            $display("%s: bus owner changed %0d times instead of twice", name, owners.size());
            stopWithFailure();
        end
        checkOwner({name, " first owner"}, ownData, owners[0]);
        checkOwner({name, " second owner"}, ownFetch, owners[1]);
    endtask

    // done and RAM writes must stay off while held
    always @(negedge clk) begin
        if (!rst && hold && (fetchResp.done || dataResp.done || dut.ramPort.we)) begin
            $display("done or RAM write enable seen while hold was high");
            stopWithFailure();
        end
    end

    initial begin
        cycles = 0;
        while (cycles < OpLimit * CyclesPerOp) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", cycles);
        stopWithFailure();
    end

    initial begin
        byteAddr_t   addr;
        accessLen_t  len;
        logic [31:0] r;
        seed     = 94;
        holdMode = 1'b0;
        rst      = 1'b1;
        hold     = 1'b0;
        fetchReq = '0;
        dataReq  = '0;
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        checkOwner("after reset", ownNone, busOwner);

        repeat (40) begin
            addr = randAligned();
            doStore(lenWord, addr, $random(seed));
            doLoad("word store then load", lenWord, addr);
        end
        repeat (40) begin
            len = randShortLen();
            doLoad("short load", len, pickAddr(len));
        end
        repeat (30) begin
            len  = randShortLen();
            addr = pickAddr(len);
            doStore(len, addr, $random(seed));
            doLoad("merged word load", lenWord, {addr[`MEM_ADDR_WIDTH-1:2], 2'b00});
        end
        repeat (30) begin
            doFetch("fetch", pickAddr(lenWord));
        end
        repeat (10) begin
            runDual("dual request", pickAddr(lenWord), pickAddr(lenWord));
        end

        // mixed traffic under random hold
        holdMode = 1'b1;
        repeat (60) begin
            r = $random(seed);
            case (r[1:0])
                2'd0: doStore(lenWord, randAligned(), $random(seed));
                2'd1: begin
                    len = randShortLen();
                    doStore(len, pickAddr(len), $random(seed));
                end
                2'd2: begin
                    len = r[2] ? lenWord : randShortLen();
                    doLoad("load under hold", len, pickAddr(len));
                end
                default: doFetch("fetch under hold", pickAddr(lenWord));
            endcase
        end
        holdMode = 1'b0;
        hold     = 1'b0;

        $display("No errors");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/memTypesPkg.sv
design/memBusPkg.sv
design/byteRam.sv
design/byteCounter.sv
design/memPortDriver.sv
design/wordAssembler.sv
design/memCtrlFsm.sv
design/memSubsystem.sv
verification/memSubsystem_assert.sv
verification/memSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
